//--- files.f
+incdir+logic
logic/rv_exec_pkg.sv
logic/stage_if.sv
logic/inst_decoder.sv
logic/exec_alu.sv
logic/mem_access.sv
logic/rv_exec_top.sv
testbench/clk_rst_gen.sv
testbench/tb_rv_exec.sv

//--- logic/exec_alu.sv
// Execute stage
`include "rv_exec_consts.svh"

module exec_alu (
  input  logic  i_clk,
  input  logic  i_rst_n,
  dec_ex_if.dst i_de,
  ex_mem_if.src o_em
);
  import rv_exec_pkg::*;

  xlen_t op_a;
  xlen_t op_b;
  xlen_t sum;
  xlen_t diff;
  xlen_t alu_result;
  xlen_t cmp_diff;
  xlen_t jalr_target;
  xlen_t next_pc;
  logic  cmp_zero;
  logic  cmp_less;
  logic  taken;

  assign op_a = (i_de.a_sel == A_PC) ? i_de.pc : i_de.rs1;

  always_comb begin
    case (i_de.b_sel)
      B_RS2:   op_b = i_de.rs2;
      B_IMM:   op_b = i_de.imm;
      default: op_b = xlen_t'(4);
    endcase
  end

  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;

  always_comb begin
    case (i_de.alu_op)
      ALU_COPY_IMM: alu_result = i_de.imm;
      ALU_ADDW:     alu_result = {{(`RV_XLEN-32){sum[31]}}, sum[31:0]};
      ALU_SUB:      alu_result = diff;
      ALU_SLT:      alu_result = {{(`RV_XLEN-1){1'b0}}, diff[`RV_XLEN-1]};
      default:      alu_result = sum;
    endcase
  end

  // Branch compare works on the raw register values
  assign cmp_diff = i_de.rs1 - i_de.rs2;
  assign cmp_zero = (cmp_diff == '0);
  assign cmp_less = cmp_diff[`RV_XLEN-1];

  always_comb begin
    case (i_de.branch)
      BR_JAL:  taken = 1'b1;
      BR_EQ:   taken = cmp_zero;
      BR_NE:   taken = !cmp_zero;
      BR_LT:   taken = cmp_less;
      BR_GE:   taken = !cmp_less;
      default: taken = 1'b0;
    endcase
  end

  assign jalr_target = i_de.rs1 + i_de.imm;

  always_comb begin
    if (i_de.branch == BR_JALR) begin
      next_pc = {jalr_target[`RV_XLEN-1:1], 1'b0};
    end else if (taken) begin
      next_pc = i_de.pc + i_de.imm;
    end else begin
      next_pc = i_de.pc + xlen_t'(4);
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_em.valid   <= 1'b0;
      o_em.we      <= 1'b0;
      o_em.mem_op  <= MEM_NONE;
      o_em.ebreak  <= 1'b0;
      o_em.illegal <= 1'b0;
    end else begin
      o_em.valid   <= i_de.valid;
      o_em.we      <= i_de.we;
      o_em.mem_op  <= i_de.mem_op;
      o_em.ebreak  <= i_de.ebreak;
      o_em.illegal <= i_de.illegal;
    end
  end

  always_ff @(posedge i_clk) begin
    o_em.alu_result <= alu_result;
    o_em.store_data <= i_de.rs2;
    o_em.next_pc    <= next_pc;
    o_em.rd         <= i_de.rd;
  end

  a_branch_no_mem : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_de.valid && i_de.branch != BR_NONE |-> i_de.mem_op == MEM_NONE
  );

endmodule

//--- logic/inst_decoder.sv
// Decode stage
`include "rv_exec_consts.svh"

module inst_decoder (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_valid,
  input  rv_exec_pkg::inst_t i_inst,
  input  rv_exec_pkg::xlen_t i_pc,
  input  rv_exec_pkg::xlen_t i_rs1,
  input  rv_exec_pkg::xlen_t i_rs2,
  dec_ex_if.src              o_de
);
  import rv_exec_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  xlen_t      imm;
  logic       we;
  a_sel_e     a_sel;
  b_sel_e     b_sel;
  alu_op_e    alu_op;
  branch_e    branch;
  mem_op_e    mem_op;
  logic       ebreak;
  logic       illegal;

  assign opcode = i_inst[6:0];
  assign rd     = i_inst[11:7];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`RV_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(`RV_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    imm     = imm_i;
    we      = 1'b0;
    a_sel   = A_RS1;
    b_sel   = B_IMM;
    alu_op  = ALU_ADD;
    branch  = BR_NONE;
    mem_op  = MEM_NONE;
    ebreak  = 1'b0;
    illegal = 1'b0;
    case (opcode)
      `RV_OP_LUI: begin
        imm    = imm_u;
        we     = 1'b1;
        alu_op = ALU_COPY_IMM;
      end
      `RV_OP_AUIPC: begin
        imm   = imm_u;
        we    = 1'b1;
        a_sel = A_PC;
      end
      // Link value is pc + 4, the target comes from the imm
      `RV_OP_JAL: begin
        imm    = imm_j;
        we     = 1'b1;
        a_sel  = A_PC;
        b_sel  = B_FOUR;
        branch = BR_JAL;
      end
      `RV_OP_JALR: begin
        we      = 1'b1;
        a_sel   = A_PC;
        b_sel   = B_FOUR;
        branch  = BR_JALR;
        illegal = (funct3 != 3'b000);
      end
      `RV_OP_BRANCH: begin
        imm   = imm_b;
        b_sel = B_RS2;
        case (funct3)
          3'b000:  branch = BR_EQ;
          3'b001:  branch = BR_NE;
          3'b100:  branch = BR_LT;
          3'b101:  branch = BR_GE;
          default: illegal = 1'b1;
        endcase
      end
      `RV_OP_LOAD: begin
        we = 1'b1;
        case (funct3)
          3'b000:  mem_op = MEM_LB;
          3'b001:  mem_op = MEM_LH;
          3'b010:  mem_op = MEM_LW;
          3'b011:  mem_op = MEM_LD;
          3'b100:  mem_op = MEM_LBU;
          3'b101:  mem_op = MEM_LHU;
          3'b110:  mem_op = MEM_LWU;
          default: illegal = 1'b1;
        endcase
      end
      `RV_OP_STORE: begin
        imm = imm_s;
        case (funct3)
          3'b000:  mem_op = MEM_SB;
          3'b001:  mem_op = MEM_SH;
          3'b010:  mem_op = MEM_SW;
          3'b011:  mem_op = MEM_SD;
          default: illegal = 1'b1;
        endcase
      end
      `RV_OP_OPIMM: begin
        we = 1'b1;
        case (funct3)
          3'b000:  alu_op = ALU_ADD;
          3'b010:  alu_op = ALU_SLT;
          default: illegal = 1'b1;
        endcase
      end
      `RV_OP_OPIMM32: begin
        we      = 1'b1;
        alu_op  = ALU_ADDW;
        illegal = (funct3 != 3'b000);
      end
      `RV_OP_OP: begin
        we    = 1'b1;
        b_sel = B_RS2;
        case ({funct7, funct3})
          10'b0000000_000: alu_op = ALU_ADD;
          10'b0100000_000: alu_op = ALU_SUB;
          10'b0000000_010: alu_op = ALU_SLT;
          default:         illegal = 1'b1;
        endcase
      end
      `RV_OP_SYSTEM: begin
        ebreak  = (i_inst == `RV_INST_EBREAK);
        illegal = !ebreak;
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      we     = 1'b0;
      mem_op = MEM_NONE;
      branch = BR_NONE;
    end
    // x0 is never written
    if (rd == '0) begin
      we = 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_de.valid   <= 1'b0;
      o_de.we      <= 1'b0;
      o_de.branch  <= BR_NONE;
      o_de.mem_op  <= MEM_NONE;
      o_de.ebreak  <= 1'b0;
      o_de.illegal <= 1'b0;
    end else begin
      o_de.valid   <= i_valid;
      o_de.we      <= i_valid & we;
      o_de.branch  <= i_valid ? branch : BR_NONE;
      o_de.mem_op  <= i_valid ? mem_op : MEM_NONE;
      o_de.ebreak  <= i_valid & ebreak;
      o_de.illegal <= i_valid & illegal;
    end
  end

  always_ff @(posedge i_clk) begin
    o_de.pc     <= i_pc;
    o_de.rs1    <= i_rs1;
    o_de.rs2    <= i_rs2;
    o_de.imm    <= imm;
    o_de.rd     <= rd;
    o_de.a_sel  <= a_sel;
    o_de.b_sel  <= b_sel;
    o_de.alu_op <= alu_op;
  end

  a_illegal_no_mem : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_de.illegal |-> o_de.mem_op == MEM_NONE
  );

endmodule

//--- logic/mem_access.sv
// Memory and writeback stage
`include "rv_exec_consts.svh"

module mem_access (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  ex_mem_if.dst                 i_em,
  output logic                  o_wb_valid,
  output rv_exec_pkg::reg_idx_t o_wb_rd,
  output logic                  o_wb_we,
  output rv_exec_pkg::xlen_t    o_wb_data,
  output rv_exec_pkg::xlen_t    o_next_pc,
  output logic                  o_ebreak,
  output logic                  o_illegal
);
  import rv_exec_pkg::*;

  xlen_t                  dmem [`RV_DMEM_DWORDS];
  logic [`RV_DMEM_AW-1:0] dw_idx;
  logic [2:0]             byte_off;
  logic [5:0]             bit_off;
  xlen_t                  load_raw;
  xlen_t                  load_val;
  xlen_t                  store_shifted;
  logic [7:0]             byte_en;
  logic                   is_load;
  logic                   aligned;
  logic                   store_en;

  assign dw_idx        = i_em.alu_result[`RV_DMEM_AW+2:3];
  assign byte_off      = i_em.alu_result[2:0];
  assign bit_off       = {byte_off, 3'b000};
  assign load_raw      = dmem[dw_idx] >> bit_off;
  assign store_shifted = i_em.store_data << bit_off;

  always_comb begin
    load_val = load_raw;
    byte_en  = 8'h00;
    is_load  = 1'b0;
    aligned  = 1'b1;
    case (i_em.mem_op)
      MEM_LB: begin
        load_val = {{(`RV_XLEN-8){load_raw[7]}}, load_raw[7:0]};
        is_load  = 1'b1;
      end
      MEM_LBU: begin
        load_val = {{(`RV_XLEN-8){1'b0}}, load_raw[7:0]};
        is_load  = 1'b1;
      end
      MEM_LH: begin
        load_val = {{(`RV_XLEN-16){load_raw[15]}}, load_raw[15:0]};
        is_load  = 1'b1;
        aligned  = (byte_off[0] == 1'b0);
      end
      MEM_LHU: begin
        load_val = {{(`RV_XLEN-16){1'b0}}, load_raw[15:0]};
        is_load  = 1'b1;
        aligned  = (byte_off[0] == 1'b0);
      end
      MEM_LW: begin
        load_val = {{(`RV_XLEN-32){load_raw[31]}}, load_raw[31:0]};
        is_load  = 1'b1;
        aligned  = (byte_off[1:0] == 2'b00);
      end
      MEM_LWU: begin
        load_val = {{(`RV_XLEN-32){1'b0}}, load_raw[31:0]};
        is_load  = 1'b1;
        aligned  = (byte_off[1:0] == 2'b00);
      end
      MEM_LD: begin
        is_load = 1'b1;
        aligned = (byte_off == 3'b000);
      end
      MEM_SB: byte_en = 8'h01 << byte_off;
      MEM_SH: begin
        byte_en = 8'h03 << byte_off;
        aligned = (byte_off[0] == 1'b0);
      end
      MEM_SW: begin
        byte_en = 8'h0f << byte_off;
        aligned = (byte_off[1:0] == 2'b00);
      end
      MEM_SD: begin
        byte_en = 8'hff;
        aligned = (byte_off == 3'b000);
      end
      default: ;
    endcase
  end

  assign store_en = i_em.valid && (byte_en != 8'h00);

  // Byte-lane merge into the addressed doubleword
  always_ff @(posedge i_clk) begin
    if (store_en) begin
      for (int i = 0; i < 8; i++) begin
        if (byte_en[i]) begin
          dmem[dw_idx][i*8 +: 8] <= store_shifted[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_wb_valid <= 1'b0;
      o_wb_we    <= 1'b0;
      o_ebreak   <= 1'b0;
      o_illegal  <= 1'b0;
    end else begin
      o_wb_valid <= i_em.valid;
      o_wb_we    <= i_em.valid & i_em.we;
      o_ebreak   <= i_em.valid & i_em.ebreak;
      o_illegal  <= i_em.valid & i_em.illegal;
    end
  end

  always_ff @(posedge i_clk) begin
    o_wb_rd   <= i_em.rd;
    o_wb_data <= is_load ? load_val : i_em.alu_result;
    o_next_pc <= i_em.next_pc;
  end

  a_access_aligned : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_em.valid && i_em.mem_op != MEM_NONE |-> aligned
  );

endmodule

//--- logic/rv_exec_consts.svh
// Execute pipeline constants
`ifndef RV_EXEC_CONSTS_SVH
`define RV_EXEC_CONSTS_SVH

`define RV_XLEN        64
`define RV_ILEN        32
`define RV_RIDX_W      5

// Data memory geometry, depth must stay a power of two
`define RV_DMEM_DWORDS 256
`define RV_DMEM_AW     8

`define RV_OP_LUI      7'b0110111
`define RV_OP_AUIPC    7'b0010111
`define RV_OP_JAL      7'b1101111
`define RV_OP_JALR     7'b1100111
`define RV_OP_BRANCH   7'b1100011
`define RV_OP_LOAD     7'b0000011
`define RV_OP_STORE    7'b0100011
`define RV_OP_OPIMM    7'b0010011
`define RV_OP_OPIMM32  7'b0011011
`define RV_OP_OP       7'b0110011
`define RV_OP_SYSTEM   7'b1110011

`define RV_INST_EBREAK 32'h0010_0073

`endif

//--- logic/rv_exec_pkg.sv
// Execute pipeline types
`include "rv_exec_consts.svh"

package rv_exec_pkg;

  typedef logic [`RV_XLEN-1:0]   xlen_t;
  typedef logic [`RV_ILEN-1:0]   inst_t;
  typedef logic [`RV_RIDX_W-1:0] reg_idx_t;

  typedef enum logic [2:0] {
    ALU_COPY_IMM,
    ALU_ADD,
    // Add, keep low word, sign-extend
    ALU_ADDW,
    ALU_SUB,
    // Sign of the difference
    ALU_SLT
  } alu_op_e;

  typedef enum logic {
    A_RS1,
    A_PC
  } a_sel_e;

  typedef enum logic [1:0] {
    B_RS2,
    B_IMM,
    B_FOUR
  } b_sel_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_JAL,
    BR_JALR,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE
  } branch_e;

  typedef enum logic [3:0] {
    MEM_NONE,
    MEM_LB,
    MEM_LBU,
    MEM_LH,
    MEM_LHU,
    MEM_LW,
    MEM_LWU,
    MEM_LD,
    MEM_SB,
    MEM_SH,
    MEM_SW,
    MEM_SD
  } mem_op_e;

endpackage

//--- logic/rv_exec_top.sv
// RV64I execute pipeline

module rv_exec_top (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_valid,
  input  rv_exec_pkg::inst_t    i_inst,
  input  rv_exec_pkg::xlen_t    i_pc,
  input  rv_exec_pkg::xlen_t    i_rs1,
  input  rv_exec_pkg::xlen_t    i_rs2,
  output logic                  o_wb_valid,
  output rv_exec_pkg::reg_idx_t o_wb_rd,
  output logic                  o_wb_we,
  output rv_exec_pkg::xlen_t    o_wb_data,
  output rv_exec_pkg::xlen_t    o_next_pc,
  output logic                  o_ebreak,
  output logic                  o_illegal
);

  dec_ex_if de_bus ();
  ex_mem_if em_bus ();

  inst_decoder u_decoder (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .i_inst  (i_inst),
    .i_pc    (i_pc),
    .i_rs1   (i_rs1),
    .i_rs2   (i_rs2),
    .o_de    (de_bus.src)
  );

  exec_alu u_alu (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_de    (de_bus.dst),
    .o_em    (em_bus.src)
  );

  mem_access u_mem (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_em       (em_bus.dst),
    .o_wb_valid (o_wb_valid),
    .o_wb_rd    (o_wb_rd),
    .o_wb_we    (o_wb_we),
    .o_wb_data  (o_wb_data),
    .o_next_pc  (o_next_pc),
    .o_ebreak   (o_ebreak),
    .o_illegal  (o_illegal)
  );

endmodule

//--- logic/stage_if.sv
// Inter-stage buses

interface dec_ex_if;
  import rv_exec_pkg::*;

  logic     valid;
  xlen_t    pc;
  xlen_t    rs1;
  xlen_t    rs2;
  xlen_t    imm;
  reg_idx_t rd;
  logic     we;
  a_sel_e   a_sel;
  b_sel_e   b_sel;
  alu_op_e  alu_op;
  branch_e  branch;
  mem_op_e  mem_op;
  logic     ebreak;
  logic     illegal;

  modport src (output valid, pc, rs1, rs2, imm, rd, we, a_sel, b_sel, alu_op,
               branch, mem_op, ebreak, illegal);
  modport dst (input valid, pc, rs1, rs2, imm, rd, we, a_sel, b_sel, alu_op,
               branch, mem_op, ebreak, illegal);
endinterface

interface ex_mem_if;
  import rv_exec_pkg::*;

  logic     valid;
  xlen_t    alu_result;
  // rs2, carried for stores
  xlen_t    store_data;
  xlen_t    next_pc;
  reg_idx_t rd;
  logic     we;
  mem_op_e  mem_op;
  logic     ebreak;
  logic     illegal;

  modport src (output valid, alu_result, store_data, next_pc, rd, we, mem_op,
               ebreak, illegal);
  modport dst (input valid, alu_result, store_data, next_pc, rd, we, mem_op,
               ebreak, illegal);
endinterface

//--- testbench/clk_rst_gen.sv
// Clock and reset generator

module clk_rst_gen (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  // Reset is seen low by four rising edges
  initial begin
    o_rst_n = 1'b0;
    repeat (4) @(posedge o_clk);
    #1 o_rst_n = 1'b1;
  end

endmodule

//--- testbench/tb_rv_exec.sv
// Execute pipeline testbench
`include "rv_exec_consts.svh"

module tb_rv_exec;
  import rv_exec_pkg::*;

  typedef struct packed {
    logic     valid;
    inst_t    inst;
    xlen_t    pc;
    xlen_t    rs1;
    xlen_t    rs2;
    logic     we;
    reg_idx_t rd;
    xlen_t    data;
    xlen_t    next_pc;
    logic     ebreak;
    logic     illegal;
  } vec_t;

  localparam int RAND_COUNT = 200;

  logic        clk;
  logic        rst_n;
  logic        valid;
  inst_t       inst;
  xlen_t       pc;
  xlen_t       rs1;
  xlen_t       rs2;
  logic        wb_valid;
  reg_idx_t    wb_rd;
  logic        wb_we;
  xlen_t       wb_data;
  xlen_t       next_pc;
  logic        ebreak;
  logic        illegal;

  vec_t        table_q[$];
  vec_t        exp_q[$];
  int unsigned due_q[$];
  xlen_t       tbl_pc = 64'h1000;
  int unsigned cycles = 0;
  int unsigned timeout_limit = 0;
  logic [31:0] rng_state = 32'h6dc6_548f;

  clk_rst_gen u_clk_rst (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  rv_exec_top UUT (
    .i_clk      (clk),
    .i_rst_n    (rst_n),
    .i_valid    (valid),
    .i_inst     (inst),
    .i_pc       (pc),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_wb_valid (wb_valid),
    .o_wb_rd    (wb_rd),
    .o_wb_we    (wb_we),
    .o_wb_data  (wb_data),
    .o_next_pc  (next_pc),
    .o_ebreak   (ebreak),
    .o_illegal  (illegal)
  );

  // Encoders with source register fields fixed to x1 and x2
  function automatic inst_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                  input reg_idx_t rd);
    return {f7, 5'd2, 5'd1, f3, rd, `RV_OP_OP};
  endfunction

  function automatic inst_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                  input reg_idx_t rd, input logic [6:0] op);
    return {imm, 5'd1, f3, rd, op};
  endfunction

  function automatic inst_t enc_s(input logic [11:0] imm, input logic [2:0] f3);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic inst_t enc_b(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
  endfunction

  function automatic inst_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                  input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic inst_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
  endfunction

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic vec_t random_vec(input xlen_t pc_val);
    vec_t        v;
    logic [31:0] r;
    xlen_t       diff;
    v.valid   = 1'b1;
    v.pc      = pc_val;
    v.rs1     = {next_random(), next_random()};
    v.rs2     = {next_random(), next_random()};
    r         = next_random();
    v.rd      = r[4:0];
    v.we      = (r[4:0] != 5'd0);
    v.next_pc = pc_val + 64'd4;
    v.ebreak  = 1'b0;
    v.illegal = 1'b0;
    diff      = v.rs1 - v.rs2;
    case (r[9:8])
      2'd0: begin
        v.inst = enc_r(7'h00, 3'b000, v.rd);
        v.data = v.rs1 + v.rs2;
      end
      2'd1: begin
        v.inst = enc_r(7'h20, 3'b000, v.rd);
        v.data = diff;
      end
      2'd2: begin
        v.inst = enc_i(r[31:20], 3'b000, v.rd, `RV_OP_OPIMM);
        v.data = v.rs1 + {{52{r[31]}}, r[31:20]};
      end
      default: begin
        v.inst = enc_r(7'h00, 3'b010, v.rd);
        v.data = {63'd0, diff[63]};
      end
    endcase
    return v;
  endfunction

  task automatic add_entry(input logic vld, input inst_t i, input xlen_t a, input xlen_t b,
                           input logic we, input reg_idx_t rd, input xlen_t data,
                           input xlen_t npc, input logic brk, input logic ill);
    vec_t v;
    v = {vld, i, tbl_pc, a, b, we, rd, data, npc, brk, ill};
    table_q.push_back(v);
    if (vld) begin
      tbl_pc = tbl_pc + 64'd4;
    end
  endtask

  task automatic add_vec(input inst_t i, input xlen_t a, input xlen_t b, input logic we,
                         input reg_idx_t rd, input xlen_t data, input xlen_t npc);
    add_entry(1'b1, i, a, b, we, rd, data, npc, 1'b0, 1'b0);
  endtask

  task automatic add_flag(input inst_t i, input logic brk, input logic ill);
    add_entry(1'b1, i, '0, '0, 1'b0, '0, '0, tbl_pc + 64'd4, brk, ill);
  endtask

  task automatic add_gap();
    add_entry(1'b0, '0, '0, '0, 1'b0, '0, '0, '0, 1'b0, 1'b0);
  endtask

  task automatic build_table();
    // Arithmetic
    add_vec(enc_u(20'h12345, 5'd5, `RV_OP_LUI), 0, 0, 1, 5'd5, 64'h1234_5000, tbl_pc + 4);
    add_vec(enc_u(20'h80000, 5'd6, `RV_OP_LUI), 0, 0, 1, 5'd6, 64'hFFFF_FFFF_8000_0000,
            tbl_pc + 4);
    add_vec(enc_u(20'h00001, 5'd7, `RV_OP_AUIPC), 0, 0, 1, 5'd7, tbl_pc + 64'h1000, tbl_pc + 4);
    add_vec(enc_u(20'hFFFFF, 5'd7, `RV_OP_AUIPC), 0, 0, 1, 5'd7, tbl_pc - 64'h1000, tbl_pc + 4);
    add_vec(enc_r(7'h00, 3'b000, 5'd8), 64'h0123_4567_89AB_CDEF, 64'h1111_1111_1111_1111,
            1, 5'd8, 64'h1234_5678_9ABC_DF00, tbl_pc + 4);
    add_vec(enc_r(7'h20, 3'b000, 5'd9), 3, 5, 1, 5'd9, -64'd2, tbl_pc + 4);
    add_vec(enc_i(12'hFFF, 3'b000, 5'd10, `RV_OP_OPIMM), 10, 0, 1, 5'd10, 9, tbl_pc + 4);
    add_vec(enc_i(12'h001, 3'b000, 5'd11, `RV_OP_OPIMM32), 64'h7FFF_FFFF, 0, 1, 5'd11,
            64'hFFFF_FFFF_8000_0000, tbl_pc + 4);
    add_vec(enc_i(12'h003, 3'b000, 5'd11, `RV_OP_OPIMM32), 64'h1234_5678_0000_0005, 0, 1,
            5'd11, 8, tbl_pc + 4);
    add_vec(enc_r(7'h00, 3'b010, 5'd12), -64'd1, 1, 1, 5'd12, 1, tbl_pc + 4);
    add_vec(enc_r(7'h00, 3'b010, 5'd12), 5, -64'd3, 1, 5'd12, 0, tbl_pc + 4);
    add_vec(enc_i(12'h000, 3'b010, 5'd13, `RV_OP_OPIMM), -64'd7, 0, 1, 5'd13, 1, tbl_pc + 4);
    add_gap();
    // Branches taken then not taken
    add_vec(enc_b(13'd16, 3'b000), 7, 7, 0, '0, '0, tbl_pc + 16);
    add_vec(enc_b(13'd16, 3'b000), 7, 8, 0, '0, '0, tbl_pc + 4);
    add_vec(enc_b(13'd16, 3'b001), 7, 8, 0, '0, '0, tbl_pc + 16);
    add_vec(enc_b(13'd16, 3'b001), 7, 7, 0, '0, '0, tbl_pc + 4);
    add_vec(enc_b(13'h1FF8, 3'b100), -64'd5, 3, 0, '0, '0, tbl_pc - 8);
    add_vec(enc_b(13'h1FF8, 3'b100), 3, -64'd5, 0, '0, '0, tbl_pc + 4);
    add_vec(enc_b(13'd16, 3'b101), -64'd2, -64'd9, 0, '0, '0, tbl_pc + 16);
    add_vec(enc_b(13'd16, 3'b101), -64'd9, -64'd2, 0, '0, '0, tbl_pc + 4);
    add_vec(enc_j(21'h100, 5'd1), 0, 0, 1, 5'd1, tbl_pc + 4, tbl_pc + 64'h100);
    add_vec(enc_i(12'h004, 3'b000, 5'd1, `RV_OP_JALR), 64'h3001, 0, 1, 5'd1, tbl_pc + 4,
            64'h3004);
    add_gap();
    add_gap();
    // Stores merge into one doubleword and loads follow back to back
    add_vec(enc_s(12'h000, 3'b011), 64'h100, 64'h1122_3344_5566_7788, 0, '0, '0, tbl_pc + 4);
    add_vec(enc_s(12'h001, 3'b000), 64'h100, 64'hFFFF_FFFF_FFFF_FFAB, 0, '0, '0, tbl_pc + 4);
    add_vec(enc_s(12'h002, 3'b001), 64'h100, 64'h0000_0000_0000_CDEF, 0, '0, '0, tbl_pc + 4);
    add_vec(enc_s(12'h004, 3'b010), 64'h100, 64'h0000_0000_8899_AABB, 0, '0, '0, tbl_pc + 4);
    add_vec(enc_i(12'h000, 3'b011, 5'd14, `RV_OP_LOAD), 64'h100, 0, 1, 5'd14,
            64'h8899_AABB_CDEF_AB88, tbl_pc + 4);
    add_vec(enc_i(12'h000, 3'b000, 5'd14, `RV_OP_LOAD), 64'h100, 0, 1, 5'd14,
            64'hFFFF_FFFF_FFFF_FF88, tbl_pc + 4);
    add_vec(enc_i(12'h001, 3'b100, 5'd15, `RV_OP_LOAD), 64'h100, 0, 1, 5'd15, 64'hAB,
            tbl_pc + 4);
    add_vec(enc_i(12'h001, 3'b000, 5'd15, `RV_OP_LOAD), 64'h100, 0, 1, 5'd15,
            64'hFFFF_FFFF_FFFF_FFAB, tbl_pc + 4);
    add_vec(enc_i(12'h002, 3'b001, 5'd16, `RV_OP_LOAD), 64'h100, 0, 1, 5'd16,
            64'hFFFF_FFFF_FFFF_CDEF, tbl_pc + 4);
    add_vec(enc_i(12'h002, 3'b101, 5'd16, `RV_OP_LOAD), 64'h100, 0, 1, 5'd16, 64'hCDEF,
            tbl_pc + 4);
    add_vec(enc_i(12'h000, 3'b001, 5'd17, `RV_OP_LOAD), 64'h100, 0, 1, 5'd17,
            64'hFFFF_FFFF_FFFF_AB88, tbl_pc + 4);
    add_vec(enc_i(12'h004, 3'b010, 5'd18, `RV_OP_LOAD), 64'h100, 0, 1, 5'd18,
            64'hFFFF_FFFF_8899_AABB, tbl_pc + 4);
    add_vec(enc_i(12'h004, 3'b110, 5'd18, `RV_OP_LOAD), 64'h100, 0, 1, 5'd18,
            64'h0000_0000_8899_AABB, tbl_pc + 4);
    add_vec(enc_i(12'h000, 3'b010, 5'd19, `RV_OP_LOAD), 64'h100, 0, 1, 5'd19,
            64'hFFFF_FFFF_CDEF_AB88, tbl_pc + 4);
    add_vec(enc_i(12'h007, 3'b100, 5'd19, `RV_OP_LOAD), 64'h100, 0, 1, 5'd19, 64'h88,
            tbl_pc + 4);
    add_gap();
    // x0 target, ebreak and an unknown opcode with rd x31
    add_vec(enc_i(12'h005, 3'b000, 5'd0, `RV_OP_OPIMM), 1, 0, 0, '0, '0, tbl_pc + 4);
    add_flag(`RV_INST_EBREAK, 1'b1, 1'b0);
    add_flag(32'h0000_0F8B, 1'b0, 1'b1);
  endtask

  task automatic check_value(input xlen_t actual, input xlen_t expected, input string what);
    if (actual !== expected) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic issue(input vec_t v);
    valid = v.valid;
    inst  = v.inst;
    pc    = v.pc;
    rs1   = v.rs1;
    rs2   = v.rs2;
    if (v.valid) begin
      exp_q.push_back(v);
      due_q.push_back(cycles + 3);
    end
  endtask

  task automatic check_result();
    vec_t        e;
    int unsigned due;
    if (exp_q.size() == 0) begin
      $display("A result came out at time %0t with no instruction in flight", $time);
      $display("STATUS: FAIL");
      $fatal(1, "Unexpected result");
    end else begin
      e   = exp_q.pop_front();
      due = due_q.pop_front();
      check_value(xlen_t'(cycles), xlen_t'(due), "result cycle");
      check_value(xlen_t'(wb_we), xlen_t'(e.we), "write enable");
      check_value(xlen_t'(ebreak), xlen_t'(e.ebreak), "ebreak flag");
      check_value(xlen_t'(illegal), xlen_t'(e.illegal), "illegal flag");
      check_value(next_pc, e.next_pc, "next pc");
      if (e.we) begin
        check_value(xlen_t'(wb_rd), xlen_t'(e.rd), "destination register");
        check_value(wb_data, e.data, "writeback data");
      end
    end
  endtask

  // Cycle count and run limit
  always @(posedge clk) begin
    if (rst_n) begin
      cycles <= cycles + 1;
    end
    if (timeout_limit != 0 && cycles >= timeout_limit) begin
      $display("Run did not finish within %0d cycles, %0d results missing", cycles,
               exp_q.size());
      $display("STATUS: FAIL");
      $fatal(1, "Timeout");
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n && wb_valid) begin
      check_result();
    end
  end

  initial begin
    valid = 1'b0;
    inst  = '0;
    pc    = '0;
    rs1   = '0;
    rs2   = '0;
    build_table();
    timeout_limit = table_q.size() + RAND_COUNT + 3 + 20;
    wait (rst_n === 1'b1);
    foreach (table_q[i]) begin
      @(posedge clk);
      #1;
      issue(table_q[i]);
    end
    for (int n = 0; n < RAND_COUNT; n++) begin
      @(posedge clk);
      #1;
      issue(random_vec(tbl_pc));
      tbl_pc = tbl_pc + 64'd4;
    end
    @(posedge clk);
    #1;
    valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule
